// File: logic/cpu_pkg.sv
// CPU package
// Widths, RV32 major opcodes and the decoded opcode set of the front end
package cpu_pkg;

  localparam int XLEN_DEFAULT = 32;
  localparam int REG_W = 5;
  localparam int TAG_W_DEFAULT = 4;  // One tag names one in-flight result
  localparam int NUM_SLOTS = 2;  // Issue width, the datapath is built for a pair

  // ####################
  // RV32 encoding fields
  // ####################
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_ADDI,
    OP_LUI,
    OP_ILLEGAL
  } opcode_e;

endpackage

// File: logic/loader.sv
// Loader
// Holds the program counter, looks up two sequential words per cycle and
// registers the pair only when both words hit
`timescale 1ns/1ps

module loader #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT
) (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            stop,
  input  logic            redirect,
  input  logic [XLEN-1:0] redirect_pc,
  output logic [XLEN-1:0] cache_addr[cpu_pkg::NUM_SLOTS],
  input  logic [31:0]     cache_data[cpu_pkg::NUM_SLOTS],
  input  logic [1:0]      cache_hit,
  output logic [1:0]      fetch_valid,
  output logic [XLEN-1:0] fetch_pc[cpu_pkg::NUM_SLOTS],
  output logic [31:0]     fetch_instr[cpu_pkg::NUM_SLOTS]
);
  import cpu_pkg::*;

  logic [XLEN-1:0] pc;
  logic pair_hit;

  assign cache_addr[0] = pc;
  assign cache_addr[1] = pc + XLEN'(4);
  assign pair_hit = &cache_hit;  // A half pair is never fetched

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= '0;
      fetch_valid <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;  // Wins over stop and over a miss
      fetch_valid <= '0;
    end else if (!stop) begin
      fetch_valid <= {2{pair_hit}};
      if (pair_hit) begin
        pc <= pc + XLEN'(8);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!stop && pair_hit) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        fetch_pc[i] <= cache_addr[i];
        fetch_instr[i] <= cache_data[i];
      end
    end
  end

endmodule

// File: logic/decoder.sv
// Decoder
// One slot: maps an RV32 word to opcode, registers and immediate and registers
// the result; unsupported encodings leave as invalid no-ops
`timescale 1ns/1ps

module decoder #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT
) (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      stop,
  input  logic                      redirect,
  input  logic                      fetch_valid,
  input  logic [XLEN-1:0]           fetch_pc,
  input  logic [31:0]               fetch_instr,
  output logic                      dec_valid,
  output logic [XLEN-1:0]           dec_pc,
  output cpu_pkg::opcode_e          dec_op,
  output logic [cpu_pkg::REG_W-1:0] dec_rd,
  output logic [cpu_pkg::REG_W-1:0] dec_rs1,
  output logic [cpu_pkg::REG_W-1:0] dec_rs2,
  output logic [XLEN-1:0]           dec_imm,
  output logic                      dec_writes_rd
);
  import cpu_pkg::*;

  opcode_e op;
  logic legal;
  logic [REG_W-1:0] rs1;
  logic [REG_W-1:0] rs2;
  logic [XLEN-1:0] imm;

  always_comb begin
    op = OP_ILLEGAL;
    rs1 = fetch_instr[19:15];
    rs2 = fetch_instr[24:20];
    imm = '0;
    case (fetch_instr[6:0])
      OPC_OP: begin
        case ({fetch_instr[31:25], fetch_instr[14:12]})
          {F7_BASE, F3_ADD_SUB}: op = OP_ADD;
          {F7_ALT, F3_ADD_SUB}: op = OP_SUB;
          {F7_BASE, F3_AND}: op = OP_AND;
          {F7_BASE, F3_OR}: op = OP_OR;
          default: op = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        rs2 = '0;  // Unused source reads x0 and resolves as ready
        imm = XLEN'($signed(fetch_instr[31:20]));
        op = (fetch_instr[14:12] == F3_ADD_SUB) ? OP_ADDI : OP_ILLEGAL;
      end
      OPC_LUI: begin
        rs1 = '0;
        rs2 = '0;
        imm = XLEN'($signed({fetch_instr[31:12], 12'b0}));
        op = OP_LUI;
      end
      default: op = OP_ILLEGAL;
    endcase
  end

  assign legal = (op != OP_ILLEGAL);

  always_ff @(posedge clock) begin
    if (!rst_n || redirect) begin
      dec_valid <= 1'b0;
      dec_writes_rd <= 1'b0;
    end else if (!stop) begin
      dec_valid <= fetch_valid && legal;
      dec_writes_rd <= fetch_valid && legal && (fetch_instr[11:7] != '0);
    end
  end

  always_ff @(posedge clock) begin
    if (!stop) begin
      dec_pc <= fetch_pc;
      dec_op <= op;
      dec_rd <= fetch_instr[11:7];
      dec_rs1 <= rs1;
      dec_rs2 <= rs2;
      dec_imm <= imm;
    end
  end

  a_valid_is_legal: assert property (@(posedge clock) disable iff (!rst_n)
    dec_valid |-> dec_op != OP_ILLEGAL);

endmodule

// File: logic/resolver.sv
// Resolver
// Looks up the four sources of a pair in the rename table, catches slot 1
// reading slot 0's result, allocates tags and writes the new mappings
`timescale 1ns/1ps

module resolver #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT,
  parameter int TAG_W = cpu_pkg::TAG_W_DEFAULT
) (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      stop,
  input  logic                      redirect,
  input  logic [1:0]                dec_valid,
  input  logic [XLEN-1:0]           dec_pc[2],
  input  cpu_pkg::opcode_e          dec_op[2],
  input  logic [cpu_pkg::REG_W-1:0] dec_rd[2],
  input  logic [cpu_pkg::REG_W-1:0] dec_rs1[2],
  input  logic [cpu_pkg::REG_W-1:0] dec_rs2[2],
  input  logic [XLEN-1:0]           dec_imm[2],
  input  logic [1:0]                dec_writes_rd,
  output logic [cpu_pkg::REG_W-1:0] query_rs[4],
  input  logic [3:0]                query_busy,
  input  logic [TAG_W-1:0]          query_tag[4],
  input  logic [XLEN-1:0]           query_value[4],
  output logic [1:0]                rename_we,
  output logic [cpu_pkg::REG_W-1:0] rename_rd[2],
  output logic [TAG_W-1:0]          rename_tag[2],
  output logic [1:0]                res_valid,
  output logic [XLEN-1:0]           res_pc[2],
  output cpu_pkg::opcode_e          res_op[2],
  output logic [cpu_pkg::REG_W-1:0] res_rd[2],
  output logic [TAG_W-1:0]          res_tag[2],
  output logic [1:0]                res_src1_ready,
  output logic [XLEN-1:0]           res_src1_value[2],
  output logic [TAG_W-1:0]          res_src1_tag[2],
  output logic [1:0]                res_src2_ready,
  output logic [XLEN-1:0]           res_src2_value[2],
  output logic [TAG_W-1:0]          res_src2_tag[2],
  output logic [XLEN-1:0]           res_imm[2]
);
  import cpu_pkg::*;

  logic [TAG_W-1:0] tag_cnt;
  logic [TAG_W-1:0] new_tag[2];
  logic [1:0] alloc;
  logic [3:0] src_ready;
  logic [XLEN-1:0] src_value[4];
  logic [TAG_W-1:0] src_tag[4];

  assign alloc = dec_valid & dec_writes_rd;
  assign new_tag[0] = tag_cnt;
  assign new_tag[1] = tag_cnt + TAG_W'(alloc[0]);  // Slot 0 takes its tag first

  // ####################
  // Source lookup
  // ####################
  always_comb begin
    for (int q = 0; q < 2 * NUM_SLOTS; q++) begin
      query_rs[q] = (q % 2 == 1) ? dec_rs2[q / 2] : dec_rs1[q / 2];
      src_ready[q] = !query_busy[q];
      src_value[q] = query_value[q];
      src_tag[q] = query_tag[q];
      if (query_rs[q] == '0) begin
        src_ready[q] = 1'b1;
        src_value[q] = '0;
      end else if (q >= 2 && alloc[0] && query_rs[q] == dec_rd[0]) begin
        src_ready[q] = 1'b0;  // Waits on the older slot of the same pair
        src_tag[q] = new_tag[0];
      end
    end
  end

  assign rename_we = (stop || redirect) ? 2'b00 : alloc;
  assign rename_rd = dec_rd;
  assign rename_tag = new_tag;

  // ####################
  // Resolve register
  // ####################
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      res_valid <= '0;
      tag_cnt <= '0;
    end else if (redirect) begin
      res_valid <= '0;
    end else if (!stop) begin
      res_valid <= dec_valid;
      tag_cnt <= new_tag[1] + TAG_W'(alloc[1]);  // Wraps at 2^TAG_W
    end
  end

  always_ff @(posedge clock) begin
    if (!stop) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        res_pc[i] <= dec_pc[i];
        res_op[i] <= dec_op[i];
        res_rd[i] <= dec_rd[i];
        res_tag[i] <= new_tag[i];
        res_src1_ready[i] <= src_ready[2 * i];
        res_src1_value[i] <= src_value[2 * i];
        res_src1_tag[i] <= src_tag[2 * i];
        res_src2_ready[i] <= src_ready[2 * i + 1];
        res_src2_value[i] <= src_value[2 * i + 1];
        res_src2_tag[i] <= src_tag[2 * i + 1];
        res_imm[i] <= dec_imm[i];
      end
    end
  end

  // No rename write and no tag consumed while the pipe is frozen
  a_stop_blocks_rename: assert property (@(posedge clock) disable iff (!rst_n)
    stop |-> (rename_we == '0) ##1 $stable(tag_cnt));

endmodule

// File: logic/issuer.sv
// Issuer
// One-deep issue register for the pair; holds it while a valid slot faces a
// full reservation station and raises the pipeline stop
`timescale 1ns/1ps

module issuer #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT,
  parameter int TAG_W = cpu_pkg::TAG_W_DEFAULT
) (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      redirect,
  input  logic [1:0]                res_valid,
  input  logic [XLEN-1:0]           res_pc[2],
  input  cpu_pkg::opcode_e          res_op[2],
  input  logic [cpu_pkg::REG_W-1:0] res_rd[2],
  input  logic [TAG_W-1:0]          res_tag[2],
  input  logic [1:0]                res_src1_ready,
  input  logic [XLEN-1:0]           res_src1_value[2],
  input  logic [TAG_W-1:0]          res_src1_tag[2],
  input  logic [1:0]                res_src2_ready,
  input  logic [XLEN-1:0]           res_src2_value[2],
  input  logic [TAG_W-1:0]          res_src2_tag[2],
  input  logic [XLEN-1:0]           res_imm[2],
  input  logic [1:0]                rs_full,
  output logic                      stop,
  output logic [1:0]                iss_valid,
  output logic [XLEN-1:0]           iss_pc[2],
  output cpu_pkg::opcode_e          iss_op[2],
  output logic [cpu_pkg::REG_W-1:0] iss_rd[2],
  output logic [TAG_W-1:0]          iss_tag[2],
  output logic [1:0]                iss_src1_ready,
  output logic [XLEN-1:0]           iss_src1_value[2],
  output logic [TAG_W-1:0]          iss_src1_tag[2],
  output logic [1:0]                iss_src2_ready,
  output logic [XLEN-1:0]           iss_src2_value[2],
  output logic [TAG_W-1:0]          iss_src2_tag[2],
  output logic [XLEN-1:0]           iss_imm[2]
);
  import cpu_pkg::*;

  assign stop = |(iss_valid & rs_full);  // Both slots leave together

  always_ff @(posedge clock) begin
    if (!rst_n || redirect) begin
      iss_valid <= '0;
    end else if (!stop) begin
      iss_valid <= res_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stop) begin
      iss_pc <= res_pc;
      iss_op <= res_op;
      iss_rd <= res_rd;
      iss_tag <= res_tag;
      iss_src1_ready <= res_src1_ready;
      iss_src1_value <= res_src1_value;
      iss_src1_tag <= res_src1_tag;
      iss_src2_ready <= res_src2_ready;
      iss_src2_value <= res_src2_value;
      iss_src2_tag <= res_src2_tag;
      iss_imm <= res_imm;
    end
  end

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_hold_check
    a_hold_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
      stop && !redirect |=> $stable(iss_valid[i]) && $stable(iss_pc[i])
        && $stable(iss_op[i]) && $stable(iss_tag[i]) && $stable(iss_src1_tag[i])
        && $stable(iss_src2_tag[i]) && $stable(iss_imm[i]));
  end

endmodule

// File: logic/comparator.sv
// Comparator
// Snoops both common data bus ports in the issue cycle and readies a waiting
// source whose tag is broadcast; port 0 wins a double match
`timescale 1ns/1ps

module comparator #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT,
  parameter int TAG_W = cpu_pkg::TAG_W_DEFAULT
) (
  input  logic                      iss_valid,
  input  logic [XLEN-1:0]           iss_pc,
  input  cpu_pkg::opcode_e          iss_op,
  input  logic [cpu_pkg::REG_W-1:0] iss_rd,
  input  logic [TAG_W-1:0]          iss_tag,
  input  logic                      iss_src1_ready,
  input  logic [XLEN-1:0]           iss_src1_value,
  input  logic [TAG_W-1:0]          iss_src1_tag,
  input  logic                      iss_src2_ready,
  input  logic [XLEN-1:0]           iss_src2_value,
  input  logic [TAG_W-1:0]          iss_src2_tag,
  input  logic [XLEN-1:0]           iss_imm,
  input  logic [1:0]                cdb_valid,
  input  logic [TAG_W-1:0]          cdb_tag[2],
  input  logic [XLEN-1:0]           cdb_value[2],
  output logic                      issue_valid,
  output logic [XLEN-1:0]           issue_pc,
  output cpu_pkg::opcode_e          issue_op,
  output logic [cpu_pkg::REG_W-1:0] issue_rd,
  output logic [TAG_W-1:0]          issue_tag,
  output logic                      issue_src1_ready,
  output logic [XLEN-1:0]           issue_src1_value,
  output logic [TAG_W-1:0]          issue_src1_tag,
  output logic                      issue_src2_ready,
  output logic [XLEN-1:0]           issue_src2_value,
  output logic [TAG_W-1:0]          issue_src2_tag,
  output logic [XLEN-1:0]           issue_imm
);

  // Returns {ready, value} for one source after the snoop
  function automatic logic [XLEN:0] snoop(input logic ready, input logic [XLEN-1:0] value,
                                          input logic [TAG_W-1:0] tag);
    logic [XLEN:0] result;
    result = {ready, value};
    if (!ready) begin
      for (int k = 1; k >= 0; k--) begin  // Port 0 is checked last so it wins
        if (cdb_valid[k] && cdb_tag[k] == tag) begin
          result = {1'b1, cdb_value[k]};
        end
      end
    end
    return result;
  endfunction

  always_comb begin
    {issue_src1_ready, issue_src1_value} = snoop(iss_src1_ready, iss_src1_value, iss_src1_tag);
    {issue_src2_ready, issue_src2_value} = snoop(iss_src2_ready, iss_src2_value, iss_src2_tag);
  end

  assign issue_valid = iss_valid;
  assign issue_pc = iss_pc;
  assign issue_op = iss_op;
  assign issue_rd = iss_rd;
  assign issue_tag = iss_tag;
  assign issue_src1_tag = iss_src1_tag;
  assign issue_src2_tag = iss_src2_tag;
  assign issue_imm = iss_imm;

endmodule

// File: logic/instr_processer.sv
// Instruction processer
// Two-wide front end of the out-of-order core: fetch, decode, source resolve,
// issue hold and result snoop, frozen as a whole by the issue stall
`timescale 1ns/1ps

module instr_processer #(
  parameter int XLEN = cpu_pkg::XLEN_DEFAULT,
  parameter int TAG_W = cpu_pkg::TAG_W_DEFAULT
) (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      redirect,
  input  logic [XLEN-1:0]           redirect_pc,
  output logic [XLEN-1:0]           cache_addr[2],
  input  logic [31:0]               cache_data[2],
  input  logic [1:0]                cache_hit,
  output logic [cpu_pkg::REG_W-1:0] query_rs[4],
  input  logic [3:0]                query_busy,
  input  logic [TAG_W-1:0]          query_tag[4],
  input  logic [XLEN-1:0]           query_value[4],
  output logic [1:0]                rename_we,
  output logic [cpu_pkg::REG_W-1:0] rename_rd[2],
  output logic [TAG_W-1:0]          rename_tag[2],
  input  logic [1:0]                rs_full,
  input  logic [1:0]                cdb_valid,
  input  logic [TAG_W-1:0]          cdb_tag[2],
  input  logic [XLEN-1:0]           cdb_value[2],
  output logic [1:0]                issue_valid,
  output logic [XLEN-1:0]           issue_pc[2],
  output cpu_pkg::opcode_e          issue_op[2],
  output logic [cpu_pkg::REG_W-1:0] issue_rd[2],
  output logic [TAG_W-1:0]          issue_tag[2],
  output logic [1:0]                issue_src1_ready,
  output logic [XLEN-1:0]           issue_src1_value[2],
  output logic [TAG_W-1:0]          issue_src1_tag[2],
  output logic [1:0]                issue_src2_ready,
  output logic [XLEN-1:0]           issue_src2_value[2],
  output logic [TAG_W-1:0]          issue_src2_tag[2],
  output logic [XLEN-1:0]           issue_imm[2]
);
  import cpu_pkg::*;

  logic stop;  // Issue stall, the only stall source
  logic [NUM_SLOTS-1:0] fetch_valid;
  logic [XLEN-1:0] fetch_pc[NUM_SLOTS];
  logic [31:0] fetch_instr[NUM_SLOTS];
  logic [NUM_SLOTS-1:0] dec_valid;
  logic [NUM_SLOTS-1:0] dec_writes_rd;
  logic [XLEN-1:0] dec_pc[NUM_SLOTS];
  opcode_e dec_op[NUM_SLOTS];
  logic [REG_W-1:0] dec_rd[NUM_SLOTS];
  logic [REG_W-1:0] dec_rs1[NUM_SLOTS];
  logic [REG_W-1:0] dec_rs2[NUM_SLOTS];
  logic [XLEN-1:0] dec_imm[NUM_SLOTS];

  // ####################
  // Resolve and issue stage registers
  // ####################
  logic [NUM_SLOTS-1:0] res_valid, iss_valid;
  logic [XLEN-1:0] res_pc[NUM_SLOTS], iss_pc[NUM_SLOTS];
  opcode_e res_op[NUM_SLOTS], iss_op[NUM_SLOTS];
  logic [REG_W-1:0] res_rd[NUM_SLOTS], iss_rd[NUM_SLOTS];
  logic [TAG_W-1:0] res_tag[NUM_SLOTS], iss_tag[NUM_SLOTS];
  logic [NUM_SLOTS-1:0] res_src1_ready, iss_src1_ready;
  logic [XLEN-1:0] res_src1_value[NUM_SLOTS], iss_src1_value[NUM_SLOTS];
  logic [TAG_W-1:0] res_src1_tag[NUM_SLOTS], iss_src1_tag[NUM_SLOTS];
  logic [NUM_SLOTS-1:0] res_src2_ready, iss_src2_ready;
  logic [XLEN-1:0] res_src2_value[NUM_SLOTS], iss_src2_value[NUM_SLOTS];
  logic [TAG_W-1:0] res_src2_tag[NUM_SLOTS], iss_src2_tag[NUM_SLOTS];
  logic [XLEN-1:0] res_imm[NUM_SLOTS], iss_imm[NUM_SLOTS];

  loader #(.XLEN(XLEN)) loader (.*);

  decoder #(.XLEN(XLEN)) decoder_0 (
    .clock, .rst_n, .stop, .redirect,
    .fetch_valid(fetch_valid[0]), .fetch_pc(fetch_pc[0]), .fetch_instr(fetch_instr[0]),
    .dec_valid(dec_valid[0]), .dec_pc(dec_pc[0]), .dec_op(dec_op[0]), .dec_rd(dec_rd[0]),
    .dec_rs1(dec_rs1[0]), .dec_rs2(dec_rs2[0]), .dec_imm(dec_imm[0]),
    .dec_writes_rd(dec_writes_rd[0])
  );

  decoder #(.XLEN(XLEN)) decoder_1 (
    .clock, .rst_n, .stop, .redirect,
    .fetch_valid(fetch_valid[1]), .fetch_pc(fetch_pc[1]), .fetch_instr(fetch_instr[1]),
    .dec_valid(dec_valid[1]), .dec_pc(dec_pc[1]), .dec_op(dec_op[1]), .dec_rd(dec_rd[1]),
    .dec_rs1(dec_rs1[1]), .dec_rs2(dec_rs2[1]), .dec_imm(dec_imm[1]),
    .dec_writes_rd(dec_writes_rd[1])
  );

  resolver #(.XLEN(XLEN), .TAG_W(TAG_W)) resolver (.*);

  issuer #(.XLEN(XLEN), .TAG_W(TAG_W)) issuer (.*);

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_cmp
    comparator #(.XLEN(XLEN), .TAG_W(TAG_W)) comparator (
      .iss_valid(iss_valid[i]), .iss_pc(iss_pc[i]), .iss_op(iss_op[i]),
      .iss_rd(iss_rd[i]), .iss_tag(iss_tag[i]), .iss_src1_ready(iss_src1_ready[i]),
      .iss_src1_value(iss_src1_value[i]), .iss_src1_tag(iss_src1_tag[i]),
      .iss_src2_ready(iss_src2_ready[i]), .iss_src2_value(iss_src2_value[i]),
      .iss_src2_tag(iss_src2_tag[i]), .iss_imm(iss_imm[i]),
      .cdb_valid, .cdb_tag, .cdb_value,
      .issue_valid(issue_valid[i]), .issue_pc(issue_pc[i]), .issue_op(issue_op[i]),
      .issue_rd(issue_rd[i]), .issue_tag(issue_tag[i]),
      .issue_src1_ready(issue_src1_ready[i]), .issue_src1_value(issue_src1_value[i]),
      .issue_src1_tag(issue_src1_tag[i]), .issue_src2_ready(issue_src2_ready[i]),
      .issue_src2_value(issue_src2_value[i]), .issue_src2_tag(issue_src2_tag[i]),
      .issue_imm(issue_imm[i])
    );
  end

endmodule

// File: tests/instr_processer_tb.sv
// Instruction processer testbench
// Models the instruction cache and the rename table, runs a program with
// misses, stalls, bus forwarding and one redirect, and checks every accepted
// instruction against a program-order reference
`timescale 1ns/1ps

module instr_processer_tb;
  import cpu_pkg::*;

  localparam int XLEN = 32;
  localparam int TAG_W = 4;
  localparam int MEM_WORDS = 128;
  localparam int BRANCH_WORD = 60;  // Redirect fires when this pair is accepted
  localparam int TARGET_WORD = 80;
  localparam logic [31:0] BRANCH_PC = 32'(BRANCH_WORD * 4);
  localparam logic [31:0] TARGET_PC = 32'(TARGET_WORD * 4);
  localparam int PATH_LEN = BRANCH_WORD + 2 + MEM_WORDS - TARGET_WORD;
  localparam int CYCLE_LIMIT = 18 * PATH_LEN;  // Random stalls and misses stretch each pair

  typedef struct packed {
    logic [31:0] pc;
    opcode_e op;
    logic [4:0] rd;
    logic writes;
    logic [3:0] tag;
    logic src1_ready;
    logic [31:0] src1_value;
    logic [3:0] src1_tag;
    logic src2_ready;
    logic [31:0] src2_value;
    logic [3:0] src2_tag;
    logic has_imm;
    logic [31:0] imm;
  } expect_t;

  logic clock = 1'b0;
  logic rst_n;
  logic redirect;
  logic [31:0] redirect_pc;
  logic [31:0] cache_addr[2];
  logic [31:0] cache_data[2];
  logic [1:0] cache_hit;
  logic [4:0] query_rs[4];
  logic [3:0] query_busy;
  logic [3:0] query_tag[4];
  logic [31:0] query_value[4];
  logic [1:0] rename_we;
  logic [4:0] rename_rd[2];
  logic [3:0] rename_tag[2];
  logic [1:0] rs_full;
  logic [1:0] cdb_valid;
  logic [3:0] cdb_tag[2];
  logic [31:0] cdb_value[2];
  logic [1:0] issue_valid;
  logic [31:0] issue_pc[2];
  opcode_e issue_op[2];
  logic [4:0] issue_rd[2];
  logic [3:0] issue_tag[2];
  logic [1:0] issue_src1_ready;
  logic [31:0] issue_src1_value[2];
  logic [3:0] issue_src1_tag[2];
  logic [1:0] issue_src2_ready;
  logic [31:0] issue_src2_value[2];
  logic [3:0] issue_src2_tag[2];
  logic [31:0] issue_imm[2];

  logic [31:0] mem[MEM_WORDS];
  opcode_e m_op[MEM_WORDS];
  logic [4:0] m_rd[MEM_WORDS];
  logic [4:0] m_rs1[MEM_WORDS];
  logic [4:0] m_rs2[MEM_WORDS];
  logic [31:0] m_imm[MEM_WORDS];
  int miss_left[MEM_WORDS];
  logic tbl_busy[32];
  logic [3:0] tbl_tag[32];
  logic [1:0] pend_we;
  logic [4:0] pend_rd[2];
  logic [3:0] pend_tag[2];
  expect_t expected[$];
  expect_t exp_slot[2];
  logic [1:0] exp_ok;
  logic stall;
  logic [1:0] accept;
  logic redirected;
  int errors;
  int test_start_errors;
  int tests_passed;
  int tests_failed;
  int checked;
  int cycles;

  instr_processer #(.XLEN(XLEN), .TAG_W(TAG_W)) i_instr_processer (.*);

  always #10 clock = ~clock;

  assign stall = |(issue_valid & rs_full);
  assign accept = issue_valid & ~{2{stall}};

  task automatic report_mismatch(input string field, input int slot);
    errors++;
    $display("ERROR at %0t ns: slot %0d field %s does not match the program", $time, slot, field);
  endtask

  task automatic report_failure(input string text);
    errors++;
    $display("Failure at %0t ns: %s", $time, text);
  endtask

  // ####################
  // Program
  // ####################
  task automatic put(input int w, input opcode_e op, input logic [4:0] rd,
                     input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
    if (op == OP_LUI) begin
      rs1 = '0;
    end
    if (op == OP_ADDI || op == OP_LUI) begin
      rs2 = '0;  // Unused source reads x0
    end
    case (op)
      OP_ADD: mem[w] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      OP_SUB: mem[w] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      OP_AND: mem[w] = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      OP_OR: mem[w] = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      OP_ADDI: mem[w] = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      default: mem[w] = {imm[31:12], rd, 7'b0110111};
    endcase
    m_op[w] = op;
    m_rd[w] = rd;
    m_rs1[w] = rs1;
    m_rs2[w] = rs2;
    m_imm[w] = imm;
  endtask

  task automatic put_random(input int w);
    if ($urandom_range(0, 1) == 1) begin
      put(w, OP_ADD, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
          5'($urandom_range(0, 7)), '0);
    end else begin
      put(w, OP_ADDI, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), '0,
          32'($signed(12'($urandom))));
    end
  endtask

  task automatic build_program();
    for (int w = 0; w < MEM_WORDS; w++) begin
      put_random(w);
      miss_left[w] = 0;
    end
    put(0, OP_ADD, 5'd1, 5'd2, 5'd3, '0);
    put(1, OP_SUB, 5'd4, 5'd1, 5'd5, '0);  // Reads slot 0's result
    put(2, OP_AND, 5'd5, 5'd4, 5'd0, '0);
    put(3, OP_OR, 5'd0, 5'd6, 5'd7, '0);
    put(4, OP_ADDI, 5'd6, 5'd6, '0, 32'hffff_fffb);
    put(5, OP_LUI, 5'd7, '0, '0, 32'habcd_e000);
    mem[6] = 32'hffff_ffff;
    m_op[6] = OP_ILLEGAL;
    put(7, OP_ADD, 5'd2, 5'd7, 5'd6, '0);
    put(8, OP_ADDI, 5'd3, 5'd3, '0, 32'h0000_07ff);
    put(9, OP_SUB, 5'd3, 5'd3, 5'd3, '0);
    put(10, OP_OR, 5'd1, 5'd1, 5'd2, '0);
    mem[11] = {7'b0100000, 5'd2, 5'd1, 3'b110, 5'd1, 7'b0110011};
    m_op[11] = OP_ILLEGAL;
    for (int w = BRANCH_WORD + 2; w < BRANCH_WORD + 10; w++) begin
      put(w, OP_ADD, 5'd0, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), '0);
    end
    miss_left[8] = 3;
    miss_left[19] = 2;
    miss_left[TARGET_WORD + 1] = 2;
  endtask

  // Walks the taken path in program order with its own rename state
  task automatic build_expected();
    logic busy[32];
    logic [3:0] tag[32];
    logic [3:0] cnt;
    expect_t e;
    int w;
    for (int r = 0; r < 32; r++) begin
      busy[r] = 1'b0;
      tag[r] = '0;
    end
    cnt = '0;
    w = 0;
    while (w < MEM_WORDS) begin
      if (m_op[w] != OP_ILLEGAL) begin
        e.pc = 32'(w * 4);
        e.op = m_op[w];
        e.rd = m_rd[w];
        e.writes = (m_rd[w] != '0);
        e.tag = cnt;
        e.src1_ready = !busy[m_rs1[w]];
        e.src1_value = 32'(m_rs1[w]) * 3;
        e.src1_tag = tag[m_rs1[w]];
        e.src2_ready = !busy[m_rs2[w]];
        e.src2_value = 32'(m_rs2[w]) * 3;
        e.src2_tag = tag[m_rs2[w]];
        e.has_imm = (m_op[w] == OP_ADDI || m_op[w] == OP_LUI);
        e.imm = m_imm[w];
        if (e.writes) begin
          busy[m_rd[w]] = 1'b1;
          tag[m_rd[w]] = cnt;
          cnt++;  // Wraps at 16
        end
        expected.push_back(e);
      end
      w = (w == BRANCH_WORD + 1) ? TARGET_WORD : w + 1;
    end
  endtask

  function automatic logic [32:0] snoop_source(input logic ready, input logic [31:0] value,
                                               input logic [3:0] tag);
    if (ready) begin
      return {1'b1, value};
    end
    if (cdb_valid[0] && cdb_tag[0] == tag) begin
      return {1'b1, cdb_value[0]};
    end
    if (cdb_valid[1] && cdb_tag[1] == tag) begin
      return {1'b1, cdb_value[1]};
    end
    return {1'b0, value};
  endfunction

  // ####################
  // Cycle driver
  // ####################
  task automatic drive_cycle();
    expect_t head[2];
    logic [3:0] pick;
    int w;
    int idx;
    @(negedge clock);
    rst_n = 1'b1;
    for (int i = 0; i < 2; i++) begin
      if (pend_we[i]) begin  // Writes of the edge just passed
        tbl_busy[pend_rd[i]] = 1'b1;
        tbl_tag[pend_rd[i]] = pend_tag[i];
      end
    end
    for (int i = 0; i < 2; i++) begin
      w = int'(cache_addr[i][8:2]);
      cache_data[i] = mem[w];
      cache_hit[i] = (miss_left[w] == 0);
      if (miss_left[w] > 0) begin
        miss_left[w]--;
      end
    end
    for (int q = 0; q < 4; q++) begin
      query_busy[q] = tbl_busy[query_rs[q]];
      query_tag[q] = tbl_tag[query_rs[q]];
      query_value[q] = 32'(query_rs[q]) * 3;
    end
    for (int i = 0; i < 2; i++) begin
      rs_full[i] = ($urandom_range(0, 3) == 0);
    end
    for (int s = 0; s < 2; s++) begin
      idx = (s == 1 && issue_valid[0]) ? 1 : 0;
      exp_ok[s] = (expected.size() > idx);
      head[s] = exp_ok[s] ? expected[idx] : '0;
    end
    pick = ($urandom_range(0, 1) == 1) ? head[0].src1_tag : head[1].src2_tag;
    for (int k = 0; k < 2; k++) begin
      cdb_valid[k] = 1'($urandom_range(0, 1));
      cdb_tag[k] = ($urandom_range(0, 1) == 1) ? pick : 4'($urandom);
      cdb_value[k] = $urandom;
    end
    for (int s = 0; s < 2; s++) begin
      exp_slot[s] = head[s];
      {exp_slot[s].src1_ready, exp_slot[s].src1_value} =
        snoop_source(head[s].src1_ready, head[s].src1_value, head[s].src1_tag);
      {exp_slot[s].src2_ready, exp_slot[s].src2_value} =
        snoop_source(head[s].src2_ready, head[s].src2_value, head[s].src2_tag);
    end
    redirect = 1'b0;
    if (!redirected && issue_valid[0] && !(|(issue_valid & rs_full))
        && issue_pc[0] == BRANCH_PC) begin
      redirect = 1'b1;
      redirect_pc = TARGET_PC;
      redirected = 1'b1;
    end
    #1;
    pend_we = rename_we;
    pend_rd = rename_rd;
    pend_tag = rename_tag;
    for (int s = 0; s < 2; s++) begin
      if (accept[s] && expected.size() > 0) begin
        void'(expected.pop_front());
        checked++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    @(posedge clock);
    #1;
    n = errors - test_start_errors;
    if (n == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", name, n);
    test_start_errors = errors;
  endtask

  // ####################
  // Checks
  // ####################
  for (genvar s = 0; s < 2; s++) begin : gen_issue_check
    a_known: assert property (@(posedge clock) disable iff (!rst_n) accept[s] |-> exp_ok[s])
      else report_failure("an instruction was accepted that the program does not expect");
    a_pc: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] |-> issue_pc[s] == exp_slot[s].pc) else report_mismatch("pc", s);
    a_op: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] |-> issue_op[s] == exp_slot[s].op) else report_mismatch("op", s);
    a_rd: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] |-> issue_rd[s] == exp_slot[s].rd) else report_mismatch("rd", s);
    a_tag: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] && exp_slot[s].writes |-> issue_tag[s] == exp_slot[s].tag)
      else report_mismatch("tag", s);
    a_src1: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] |-> issue_src1_ready[s] == exp_slot[s].src1_ready && (exp_slot[s].src1_ready
        ? issue_src1_value[s] == exp_slot[s].src1_value
        : issue_src1_tag[s] == exp_slot[s].src1_tag)) else report_mismatch("src1", s);
    a_src2: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] |-> issue_src2_ready[s] == exp_slot[s].src2_ready && (exp_slot[s].src2_ready
        ? issue_src2_value[s] == exp_slot[s].src2_value
        : issue_src2_tag[s] == exp_slot[s].src2_tag)) else report_mismatch("src2", s);
    a_imm: assert property (@(posedge clock) disable iff (!rst_n)
      accept[s] && exp_slot[s].has_imm |-> issue_imm[s] == exp_slot[s].imm)
      else report_mismatch("imm", s);
    a_hold: assert property (@(posedge clock) disable iff (!rst_n)
      stall && !redirect |=> $stable(issue_valid[s]) && $stable(issue_pc[s])
        && $stable(issue_op[s]) && $stable(issue_rd[s]) && $stable(issue_tag[s])
        && $stable(issue_src1_tag[s]) && $stable(issue_src2_tag[s])
        && $stable(issue_imm[s]))
      else report_failure("issue fields changed during a stall");
  end

  a_stall_rename: assert property (@(posedge clock) disable iff (!rst_n)
    stall |-> rename_we == 2'b00) else report_failure("rename write during a stall");
  a_stall_fetch: assert property (@(posedge clock) disable iff (!rst_n)
    stall && !redirect |=> $stable(cache_addr[0]))
    else report_failure("fetch address moved during a stall");
  a_reset: assert property (@(posedge clock)
    $rose(rst_n) |-> issue_valid == 2'b00 && rename_we == 2'b00 && cache_addr[0] == '0)
    else report_failure("outputs are not in their reset state after reset");

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the program did not drain within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hf4c0_7ee6));
    rst_n = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    cache_data = '{default: '0};
    cache_hit = '0;
    query_busy = '0;
    query_tag = '{default: '0};
    query_value = '{default: '0};
    rs_full = '0;
    cdb_valid = '0;
    cdb_tag = '{default: '0};
    cdb_value = '{default: '0};
    pend_we = '0;
    pend_rd = '{default: '0};
    pend_tag = '{default: '0};
    exp_ok = '0;
    redirected = 1'b0;
    errors = 0;
    test_start_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    checked = 0;
    cycles = 0;
    for (int r = 0; r < 32; r++) begin
      tbl_busy[r] = 1'b0;
      tbl_tag[r] = '0;
    end
    build_program();
    build_expected();
    repeat (2) @(posedge clock);
    drive_cycle();
    drive_cycle();
    finish_test("reset");
    while (!redirected) begin
      drive_cycle();
    end
    finish_test("stream with misses, stalls and forwarding");
    while (expected.size() > 0) begin
      drive_cycle();
    end
    finish_test("redirect");
    $display("Summary: %0d tests passed, %0d tests failed, %0d instructions checked",
             tests_passed, tests_failed, checked);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/cpu_pkg.sv
logic/loader.sv
logic/decoder.sv
logic/resolver.sv
logic/issuer.sv
logic/comparator.sv
logic/instr_processer.sv
tests/instr_processer_tb.sv

// File: Bender.yml
package:
  name: instr_processer

sources:
  - logic/cpu_pkg.sv
  - logic/loader.sv
  - logic/decoder.sv
  - logic/resolver.sv
  - logic/issuer.sv
  - logic/comparator.sv
  - logic/instr_processer.sv
  - target: test
    files:
      - tests/instr_processer_tb.sv
